/* rtl/c2h_pkg.sv */
package c2h_pkg;

   localparam int DESC_DEPTH    = 16;
   localparam int BUF_DEPTH     = 64;
   localparam int PKT_Q_DEPTH   = 8;
   localparam int MD_RING_DEPTH = 8;

   // Byte step between consecutive host words
   localparam int WORD_BYTES = 4;

   // Truncation mark in the metadata word
   localparam int MD_ERR_BIT = 31;

   localparam int DESC_PTR_W  = $clog2(DESC_DEPTH);
   localparam int BUF_PTR_W   = $clog2(BUF_DEPTH);
   localparam int PKT_Q_PTR_W = $clog2(PKT_Q_DEPTH);
   localparam int MD_PTR_W    = $clog2(MD_RING_DEPTH);

   typedef logic [31:0] word_t;
   typedef logic [31:0] addr_t;

   // Lengths are counted in words
   typedef logic [15:0] len_t;

   // Max length in the high 16 bits, destination address in the low 32
   typedef logic [47:0] desc_t;

   typedef logic [BUF_PTR_W-1:0] buf_ptr_t;
   typedef logic [MD_PTR_W-1:0]  md_ptr_t;

endpackage

/* rtl/c2h_desc_fifo.sv */
`timescale 1ns/1ps

module c2h_desc_fifo
   import c2h_pkg::*;
(
   input  logic  clk,
   input  logic  rst_n,
   input  logic  desc_wr_req,
   input  desc_t desc_wdata,
   input  logic  desc_pop,
   output logic  desc_ack,
   output logic  desc_empty,
   output desc_t desc_head,
   output logic  desc_oflow
);

   desc_t                 mem [DESC_DEPTH];
   logic [DESC_PTR_W-1:0] wr_ptr;
   logic [DESC_PTR_W-1:0] rd_ptr;
   logic [DESC_PTR_W:0]   count;
   logic                  full;
   logic                  push;
   logic                  pop;

   assign full       = (count == (DESC_PTR_W + 1)'(DESC_DEPTH));
   assign desc_empty = (count == '0);
   assign push       = desc_wr_req && !full;
   assign pop        = desc_pop && !desc_empty;
   assign desc_head  = mem[rd_ptr];

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         wr_ptr     <= '0;
         rd_ptr     <= '0;
         count      <= '0;
         desc_ack   <= 1'b0;
         desc_oflow <= 1'b0;
      end else begin
         // Every request is acked, stored or not
         desc_ack <= desc_wr_req;
         if (desc_wr_req && full) begin
            desc_oflow <= 1'b1;
         end
         if (push) begin
            wr_ptr <= wr_ptr + 1'b1;
         end
         if (pop) begin
            rd_ptr <= rd_ptr + 1'b1;
         end
         case ({push, pop})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (push) begin
         mem[wr_ptr] <= desc_wdata;
      end
   end

endmodule

/* rtl/c2h_pkt_buf.sv */
`timescale 1ns/1ps

module c2h_pkt_buf
   import c2h_pkg::*;
(
   input  logic     clk,
   input  logic     rst_n,
   input  logic     axis_valid,
   input  word_t    axis_data,
   input  logic     axis_last,
   input  buf_ptr_t rd_ptr,
   input  logic     pkt_done,
   output logic     axis_ready,
   output logic     pkt_avail,
   output len_t     pkt_len,
   output buf_ptr_t pkt_start,
   output word_t    rd_data
);

   word_t                  mem [BUF_DEPTH];
   len_t                   len_q [PKT_Q_DEPTH];
   buf_ptr_t               start_q [PKT_Q_DEPTH];

   buf_ptr_t               wr_ptr;
   buf_ptr_t               cur_start;
   len_t                   cur_len;
   logic [BUF_PTR_W:0]     used;
   logic [BUF_PTR_W:0]     freed;
   logic [PKT_Q_PTR_W-1:0] q_wr;
   logic [PKT_Q_PTR_W-1:0] q_rd;
   logic [PKT_Q_PTR_W:0]   q_cnt;
   logic                   wr_en;
   logic                   last_en;

   // Stall on a full RAM or a full length queue
   assign axis_ready = (used != (BUF_PTR_W + 1)'(BUF_DEPTH)) &&
                       (q_cnt != (PKT_Q_PTR_W + 1)'(PKT_Q_DEPTH));
   assign wr_en      = axis_valid && axis_ready;
   assign last_en    = wr_en && axis_last;

   assign pkt_avail  = (q_cnt != '0);
   assign pkt_len    = len_q[q_rd];
   assign pkt_start  = start_q[q_rd];

   // Whole packet is released at once
   assign freed = pkt_done ? pkt_len[BUF_PTR_W:0] : '0;

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         wr_ptr    <= '0;
         cur_start <= '0;
         cur_len   <= '0;
         used      <= '0;
         q_wr      <= '0;
         q_rd      <= '0;
         q_cnt     <= '0;
      end else begin
         if (wr_en) begin
            wr_ptr <= wr_ptr + 1'b1;
         end
         if (last_en) begin
            cur_len   <= '0;
            cur_start <= wr_ptr + 1'b1;
            q_wr      <= q_wr + 1'b1;
         end else if (wr_en) begin
            cur_len <= cur_len + 1'b1;
         end
         if (pkt_done) begin
            q_rd <= q_rd + 1'b1;
         end
         used <= used + (BUF_PTR_W + 1)'(wr_en) - freed;
         case ({last_en, pkt_done})
            2'b10:   q_cnt <= q_cnt + 1'b1;
            2'b01:   q_cnt <= q_cnt - 1'b1;
            default: q_cnt <= q_cnt;
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (wr_en) begin
         mem[wr_ptr] <= axis_data;
      end
      if (last_en) begin
         len_q[q_wr]   <= cur_len + 1'b1;
         start_q[q_wr] <= cur_start;
      end
      rd_data <= mem[rd_ptr];
   end

endmodule

/* rtl/c2h_data_mover.sv */
`timescale 1ns/1ps

module c2h_data_mover
   import c2h_pkg::*;
(
   input  logic     clk,
   input  logic     rst_n,
   input  logic     desc_empty,
   input  desc_t    desc_head,
   input  logic     pkt_avail,
   input  len_t     pkt_len,
   input  buf_ptr_t pkt_start,
   input  word_t    rd_data,
   input  logic     dm_ready,
   input  logic     md_grant,
   output logic     desc_pop,
   output buf_ptr_t rd_ptr,
   output logic     pkt_done,
   output logic     dm_req,
   output addr_t    dm_addr,
   output word_t    dm_data,
   output logic     md_req,
   output len_t     md_len,
   output logic     md_trunc
);

   typedef enum logic [2:0] {
      S_IDLE,
      S_READ,
      S_WRITE,
      S_SKIP,
      S_POST
   } state_t;

   state_t state;
   addr_t  desc_addr;
   len_t   desc_len;
   addr_t  next_addr;
   len_t   load_left;
   logic   fresh;
   logic   start;
   logic   load;
   logic   wr_done;

   assign desc_addr = desc_head[31:0];
   assign desc_len  = desc_head[47:32];

   assign start    = (state == S_IDLE) && pkt_avail && !desc_empty;
   assign desc_pop = start;

   // rd_data is valid once rd_ptr has stayed put for a cycle
   assign load    = (state == S_WRITE) && fresh && (load_left != '0) &&
                    (!dm_req || dm_ready);
   assign wr_done = (state == S_WRITE) && (load_left == '0) && (!dm_req || dm_ready);

   assign pkt_done = (wr_done && !md_trunc) || (state == S_SKIP);
   assign md_req   = (state == S_POST);

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         state  <= S_IDLE;
         dm_req <= 1'b0;
         fresh  <= 1'b0;
         rd_ptr <= '0;
      end else begin
         fresh <= 1'b1;
         if (dm_req && dm_ready) begin
            dm_req <= 1'b0;
         end
         case (state)
            S_IDLE: begin
               if (start) begin
                  rd_ptr <= pkt_start;
                  fresh  <= 1'b0;
                  state  <= S_READ;
               end
            end
            S_READ: begin
               state <= S_WRITE;
            end
            S_WRITE: begin
               if (load) begin
                  // Prefetch the next word while this one waits
                  dm_req <= 1'b1;
                  rd_ptr <= rd_ptr + 1'b1;
                  fresh  <= 1'b0;
               end else if (wr_done) begin
                  state <= md_trunc ? S_SKIP : S_POST;
               end
            end
            S_SKIP: begin
               state <= S_POST;
            end
            S_POST: begin
               if (md_grant) begin
                  state <= S_IDLE;
               end
            end
            default: begin
               state <= S_IDLE;
            end
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (start) begin
         md_len    <= (pkt_len < desc_len) ? pkt_len : desc_len;
         load_left <= (pkt_len < desc_len) ? pkt_len : desc_len;
         md_trunc  <= (pkt_len > desc_len);
         next_addr <= desc_addr;
      end else if (load) begin
         load_left <= load_left - 1'b1;
         next_addr <= next_addr + addr_t'(WORD_BYTES);
         dm_addr   <= next_addr;
         dm_data   <= rd_data;
      end
   end

endmodule

/* rtl/c2h_write_back.sv */
`timescale 1ns/1ps

module c2h_write_back
   import c2h_pkg::*;
(
   input  logic    clk,
   input  logic    rst_n,
   input  addr_t   md_ring_addr,
   input  logic    md_req,
   input  len_t    md_len,
   input  logic    md_trunc,
   input  logic    wb_ready,
   output logic    md_grant,
   output logic    wb_req,
   output addr_t   wb_addr,
   output word_t   wb_data,
   output md_ptr_t md_wr_ptr
);

   word_t md_word;

   // One entry only, so grant whenever the slot is free
   assign md_grant = md_req && !wb_req;

   always_comb begin
      md_word                     = '0;
      md_word[$bits(len_t)-1:0]   = md_len;
      md_word[MD_ERR_BIT]         = md_trunc;
   end

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         wb_req    <= 1'b0;
         md_wr_ptr <= '0;
      end else begin
         if (md_grant) begin
            wb_req <= 1'b1;
         end else if (wb_req && wb_ready) begin
            wb_req <= 1'b0;
            if (md_wr_ptr == md_ptr_t'(MD_RING_DEPTH - 1)) begin
               md_wr_ptr <= '0;
            end else begin
               md_wr_ptr <= md_wr_ptr + 1'b1;
            end
         end
      end
   end

   always_ff @(posedge clk) begin
      if (md_grant) begin
         wb_addr <= md_ring_addr + addr_t'(md_wr_ptr) * addr_t'(WORD_BYTES);
         wb_data <= md_word;
      end
   end

endmodule

/* rtl/c2h_mem_arb.sv */
`timescale 1ns/1ps

module c2h_mem_arb
   import c2h_pkg::*;
(
   input  logic  clk,
   input  logic  rst_n,
   input  logic  dm_req,
   input  addr_t dm_addr,
   input  word_t dm_data,
   input  logic  wb_req,
   input  addr_t wb_addr,
   input  word_t wb_data,
   input  logic  mem_wr_ready,
   output logic  dm_ready,
   output logic  wb_ready,
   output logic  mem_wr_valid,
   output addr_t mem_wr_addr,
   output word_t mem_wr_data
);

   // owner 0 is the data mover, 1 the write-back
   logic owner;
   logic locked;
   logic other_req;
   logic pick;

   assign other_req = owner ? dm_req : wb_req;

   // Held while a write waits, otherwise the other peer goes first
   assign pick = locked ? owner : (other_req ? !owner : owner);

   assign mem_wr_valid = pick ? wb_req : dm_req;
   assign mem_wr_addr  = pick ? wb_addr : dm_addr;
   assign mem_wr_data  = pick ? wb_data : dm_data;

   assign dm_ready = !pick && dm_req && mem_wr_ready;
   assign wb_ready = pick && wb_req && mem_wr_ready;

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         owner  <= 1'b0;
         locked <= 1'b0;
      end else begin
         owner  <= pick;
         locked <= mem_wr_valid && !mem_wr_ready;
      end
   end

endmodule

/* rtl/c2h_top.sv */
`timescale 1ns/1ps

module c2h_top
   import c2h_pkg::*;
(
   input  logic    clk,
   input  logic    rst_n,

   input  logic    desc_wr_req,
   input  desc_t   desc_wdata,
   output logic    desc_ack,

   input  logic    axis_valid,
   input  word_t   axis_data,
   input  logic    axis_last,
   output logic    axis_ready,

   output logic    mem_wr_valid,
   output addr_t   mem_wr_addr,
   output word_t   mem_wr_data,
   input  logic    mem_wr_ready,

   input  addr_t   md_ring_addr,
   output md_ptr_t md_wr_ptr,

   output logic    desc_oflow
);

   logic     int_rst_n;

   logic     desc_empty;
   logic     desc_pop;
   desc_t    desc_head;

   logic     pkt_avail;
   len_t     pkt_len;
   buf_ptr_t pkt_start;
   buf_ptr_t rd_ptr;
   word_t    rd_data;
   logic     pkt_done;

   logic     dm_req;
   logic     dm_ready;
   addr_t    dm_addr;
   word_t    dm_data;

   logic     md_req;
   logic     md_grant;
   len_t     md_len;
   logic     md_trunc;

   logic     wb_req;
   logic     wb_ready;
   addr_t    wb_addr;
   word_t    wb_data;

   // Local copy of reset, one cycle behind the pin
   always_ff @(posedge clk) begin
      int_rst_n <= rst_n;
   end

   c2h_desc_fifo desc_fifo0 (
      .clk         (clk),
      .rst_n       (int_rst_n),
      .desc_wr_req (desc_wr_req),
      .desc_wdata  (desc_wdata),
      .desc_pop    (desc_pop),
      .desc_ack    (desc_ack),
      .desc_empty  (desc_empty),
      .desc_head   (desc_head),
      .desc_oflow  (desc_oflow)
   );

   c2h_pkt_buf pkt_buf0 (
      .clk        (clk),
      .rst_n      (int_rst_n),
      .axis_valid (axis_valid),
      .axis_data  (axis_data),
      .axis_last  (axis_last),
      .rd_ptr     (rd_ptr),
      .pkt_done   (pkt_done),
      .axis_ready (axis_ready),
      .pkt_avail  (pkt_avail),
      .pkt_len    (pkt_len),
      .pkt_start  (pkt_start),
      .rd_data    (rd_data)
   );

   c2h_data_mover data_mover0 (
      .clk        (clk),
      .rst_n      (int_rst_n),
      .desc_empty (desc_empty),
      .desc_head  (desc_head),
      .pkt_avail  (pkt_avail),
      .pkt_len    (pkt_len),
      .pkt_start  (pkt_start),
      .rd_data    (rd_data),
      .dm_ready   (dm_ready),
      .md_grant   (md_grant),
      .desc_pop   (desc_pop),
      .rd_ptr     (rd_ptr),
      .pkt_done   (pkt_done),
      .dm_req     (dm_req),
      .dm_addr    (dm_addr),
      .dm_data    (dm_data),
      .md_req     (md_req),
      .md_len     (md_len),
      .md_trunc   (md_trunc)
   );

   c2h_write_back write_back0 (
      .clk          (clk),
      .rst_n        (int_rst_n),
      .md_ring_addr (md_ring_addr),
      .md_req       (md_req),
      .md_len       (md_len),
      .md_trunc     (md_trunc),
      .wb_ready     (wb_ready),
      .md_grant     (md_grant),
      .wb_req       (wb_req),
      .wb_addr      (wb_addr),
      .wb_data      (wb_data),
      .md_wr_ptr    (md_wr_ptr)
   );

   c2h_mem_arb mem_arb0 (
      .clk          (clk),
      .rst_n        (int_rst_n),
      .dm_req       (dm_req),
      .dm_addr      (dm_addr),
      .dm_data      (dm_data),
      .wb_req       (wb_req),
      .wb_addr      (wb_addr),
      .wb_data      (wb_data),
      .mem_wr_ready (mem_wr_ready),
      .dm_ready     (dm_ready),
      .wb_ready     (wb_ready),
      .mem_wr_valid (mem_wr_valid),
      .mem_wr_addr  (mem_wr_addr),
      .mem_wr_data  (mem_wr_data)
   );

endmodule

/* verification/c2h_tb_assert.sv */
`timescale 1ns/1ps

module c2h_tb_assert
   import c2h_pkg::*;
(
   input logic  clk,
   input logic  rst_n,
   input logic  wr_valid,
   input logic  wr_ready,
   input addr_t wr_addr,
   input word_t wr_data,
   input logic  dm_ready,
   input logic  wb_ready,
   input logic  req,
   input logic  ack
);

   int fail_count = 0;

   // A stalled write keeps its address and data
   hold_write: assert property (@(posedge clk) disable iff (!rst_n)
      wr_valid && !wr_ready |=> wr_valid && $stable(wr_addr) && $stable(wr_data))
   else begin
      fail_count++;
      $error("memory write changed while waiting for ready");
   end

   ack_after_req: assert property (@(posedge clk) disable iff (!rst_n)
      req |=> ack)
   else begin
      fail_count++;
      $error("desc_ack missing one cycle after desc_wr_req");
   end

   ack_needs_req: assert property (@(posedge clk) disable iff (!rst_n)
      ack |-> $past(req))
   else begin
      fail_count++;
      $error("desc_ack without a request in the cycle before");
   end

   // Only one peer may see its write accepted
   one_ready: assert property (@(posedge clk) disable iff (!rst_n)
      !(dm_ready && wb_ready))
   else begin
      fail_count++;
      $error("dm_ready and wb_ready high together");
   end

endmodule

/* verification/c2h_tb.sv */
`timescale 1ns/1ps

module c2h_tb
   import c2h_pkg::*;
();

   localparam int    WAIT_LIMIT = 2000;
   localparam int    RAND_PKTS  = 10;
   localparam addr_t RING_BASE  = 32'h0000_8000;

   logic    clk;
   logic    rst_n;
   logic    desc_wr_req;
   desc_t   desc_wdata;
   logic    desc_ack;
   logic    axis_valid;
   word_t   axis_data;
   logic    axis_last;
   logic    axis_ready;
   logic    mem_wr_valid;
   addr_t   mem_wr_addr;
   word_t   mem_wr_data;
   logic    mem_wr_ready;
   addr_t   md_ring_addr;
   md_ptr_t md_wr_ptr;
   logic    desc_oflow;

   int          errors;
   logic [15:0] lfsr_state;
   int          exp_slot;
   addr_t       exp_addr_q[$];
   word_t       exp_data_q[$];
   int          rand_len[RAND_PKTS];

   c2h_top dut0 (
      .clk          (clk),
      .rst_n        (rst_n),
      .desc_wr_req  (desc_wr_req),
      .desc_wdata   (desc_wdata),
      .desc_ack     (desc_ack),
      .axis_valid   (axis_valid),
      .axis_data    (axis_data),
      .axis_last    (axis_last),
      .axis_ready   (axis_ready),
      .mem_wr_valid (mem_wr_valid),
      .mem_wr_addr  (mem_wr_addr),
      .mem_wr_data  (mem_wr_data),
      .mem_wr_ready (mem_wr_ready),
      .md_ring_addr (md_ring_addr),
      .md_wr_ptr    (md_wr_ptr),
      .desc_oflow   (desc_oflow)
   );

   // Protocol checkers on the arbiter and the descriptor queue
   bind c2h_mem_arb c2h_tb_assert arb_chk0 (
      .clk      (clk),
      .rst_n    (rst_n),
      .wr_valid (mem_wr_valid),
      .wr_ready (mem_wr_ready),
      .wr_addr  (mem_wr_addr),
      .wr_data  (mem_wr_data),
      .dm_ready (dm_ready),
      .wb_ready (wb_ready),
      .req      (1'b0),
      .ack      (1'b0)
   );

   bind c2h_desc_fifo c2h_tb_assert fifo_chk0 (
      .clk      (clk),
      .rst_n    (rst_n),
      .wr_valid (1'b0),
      .wr_ready (1'b0),
      .wr_addr  (32'h0),
      .wr_data  (32'h0),
      .dm_ready (1'b0),
      .wb_ready (1'b0),
      .req      (desc_wr_req),
      .ack      (desc_ack)
   );

   initial begin
      clk = 1'b0;
      forever begin
         #5 clk = ~clk;
      end
   end

   function automatic logic [15:0] lfsr_step(input logic [15:0] s);
      return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
   endfunction

   // One LFSR step per bit taken
   function automatic int rand_bits(input int n);
      int v;
      int i;
      v = 0;
      for (i = 0; i < n; i++) begin
         v = (v << 1) | int'(lfsr_state[0]);
         lfsr_state = lfsr_step(lfsr_state);
      end
      return v;
   endfunction

   function automatic word_t pattern(input int pkt, input int idx);
      return {8'hD0, 8'(pkt), 16'(idx * 3 + 1)};
   endfunction

   // Host memory accepts writes at random
   always @(posedge clk) begin
      #1;
      mem_wr_ready = (rand_bits(1) != 0);
   end

   always @(negedge clk) begin
      if (rst_n && mem_wr_valid && mem_wr_ready) begin
         check_write(mem_wr_addr, mem_wr_data);
      end
   end

   task automatic report_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
      errors++;
      $display("Error at %0t: %s is %h, expected %h", $time, name, actual, expected);
   endtask

   task automatic check_write(input addr_t addr, input word_t data);
      addr_t exp_addr;
      word_t exp_data;
      if (exp_addr_q.size() == 0) begin
         errors++;
         $display("Unexpected memory write at %0t: addr %h data %h", $time, addr, data);
      end else begin
         exp_addr = exp_addr_q.pop_front();
         exp_data = exp_data_q.pop_front();
         if (addr !== exp_addr) begin
            report_value("mem_wr_addr", addr, exp_addr);
         end
         if (data !== exp_data) begin
            report_value("mem_wr_data", data, exp_data);
         end
      end
   endtask

   // Data words of one packet, then its metadata word in the next ring slot
   task automatic expect_packet(input addr_t dst, input int max_len, input int pkt,
                                input int len);
      int    n;
      int    i;
      word_t md;
      n = (len < max_len) ? len : max_len;
      for (i = 0; i < n; i++) begin
         exp_addr_q.push_back(dst + addr_t'(i * WORD_BYTES));
         exp_data_q.push_back(pattern(pkt, i));
      end
      md = word_t'(n);
      md[MD_ERR_BIT] = (len > max_len);
      exp_addr_q.push_back(RING_BASE + addr_t'(exp_slot * WORD_BYTES));
      exp_data_q.push_back(md);
      exp_slot = (exp_slot + 1) % MD_RING_DEPTH;
   endtask

   task automatic idle(input int n);
      repeat (n) begin
         @(posedge clk);
         #1;
      end
   endtask

   task automatic reset_dut;
      rst_n       = 1'b0;
      desc_wr_req = 1'b0;
      axis_valid  = 1'b0;
      axis_last   = 1'b0;
      idle(16);
      rst_n = 1'b1;
      exp_addr_q.delete();
      exp_data_q.delete();
      exp_slot = 0;
      idle(3);
   endtask

   task automatic push_desc(input addr_t dst, input int max_len);
      int waited;
      waited      = 0;
      desc_wr_req = 1'b1;
      desc_wdata  = {16'(max_len), dst};
      @(posedge clk);
      #1;
      desc_wr_req = 1'b0;
      while (!desc_ack && waited < WAIT_LIMIT) begin
         waited++;
         @(negedge clk);
      end
      if (!desc_ack) begin
         errors++;
         $display("Timeout at %0t: no desc_ack for descriptor %h", $time, dst);
      end
      @(posedge clk);
      #1;
   endtask

   task automatic send_word(input word_t data, input logic last);
      int waited;
      waited     = 0;
      axis_valid = 1'b1;
      axis_data  = data;
      axis_last  = last;
      @(negedge clk);
      while (!axis_ready && waited < WAIT_LIMIT) begin
         waited++;
         @(negedge clk);
      end
      if (!axis_ready) begin
         errors++;
         $display("Timeout at %0t: axis_ready stayed low", $time);
      end
      @(posedge clk);
      #1;
   endtask

   task automatic send_packet(input int pkt, input int len);
      int i;
      for (i = 0; i < len; i++) begin
         send_word(pattern(pkt, i), i == len - 1);
      end
      axis_valid = 1'b0;
      axis_last  = 1'b0;
   endtask

   task automatic wait_writes;
      int waited;
      waited = 0;
      while (exp_addr_q.size() != 0 && waited < WAIT_LIMIT) begin
         waited++;
         @(posedge clk);
         #1;
      end
      if (exp_addr_q.size() != 0) begin
         errors++;
         $display("Timeout at %0t: %0d expected memory writes never arrived",
                  $time, exp_addr_q.size());
      end
      idle(8);
   endtask

   task automatic wait_stall(output logic seen);
      int waited;
      waited = 0;
      @(negedge clk);
      while (axis_ready && waited < WAIT_LIMIT) begin
         waited++;
         @(negedge clk);
      end
      seen = !axis_ready;
      @(posedge clk);
      #1;
   endtask

   task automatic check_ring_ptr;
      if (md_wr_ptr !== md_ptr_t'(exp_slot)) begin
         report_value("md_wr_ptr", md_wr_ptr, exp_slot);
      end
   endtask

   task automatic test_reset_values;
      reset_dut();
      if (desc_ack !== 1'b0) begin
         report_value("desc_ack", desc_ack, 0);
      end
      if (mem_wr_valid !== 1'b0) begin
         report_value("mem_wr_valid", mem_wr_valid, 0);
      end
      if (desc_oflow !== 1'b0) begin
         report_value("desc_oflow", desc_oflow, 0);
      end
      if (md_wr_ptr !== '0) begin
         report_value("md_wr_ptr", md_wr_ptr, 0);
      end
      if (axis_ready !== 1'b1) begin
         report_value("axis_ready", axis_ready, 1);
      end
   endtask

   task automatic test_short_packet;
      reset_dut();
      expect_packet(32'h1000_0000, 16, 1, 5);
      push_desc(32'h1000_0000, 16);
      send_packet(1, 5);
      wait_writes();
      check_ring_ptr();
   endtask

   task automatic test_truncated_packet;
      reset_dut();
      expect_packet(32'h2000_0000, 3, 2, 7);
      push_desc(32'h2000_0000, 3);
      send_packet(2, 7);
      wait_writes();
      check_ring_ptr();
   endtask

   task automatic test_random_packets;
      int k;
      reset_dut();
      for (k = 0; k < RAND_PKTS; k++) begin
         expect_packet(32'h3000_0000 + addr_t'(k * 'h100), 16, 10 + k, rand_len[k]);
         push_desc(32'h3000_0000 + addr_t'(k * 'h100), 16);
      end
      for (k = 0; k < RAND_PKTS; k++) begin
         send_packet(10 + k, rand_len[k]);
      end
      wait_writes();
      check_ring_ptr();
   endtask

   task automatic test_buffer_full;
      int   k;
      int   m;
      logic seen;
      reset_dut();
      for (k = 0; k < 9; k++) begin
         expect_packet(32'h4000_0000 + addr_t'(k * 'h100), 8, 30 + k, 8);
      end
      // Nine packets of 8 words overrun the 64-word buffer
      fork
         begin
            for (k = 0; k < 9; k++) begin
               send_packet(30 + k, 8);
            end
         end
         begin
            wait_stall(seen);
            if (!seen) begin
               errors++;
               $display("axis_ready never dropped while the buffer filled");
            end
            for (m = 0; m < 9; m++) begin
               push_desc(32'h4000_0000 + addr_t'(m * 'h100), 8);
            end
         end
      join
      wait_writes();
      check_ring_ptr();
   endtask

   task automatic test_desc_overflow;
      int k;
      int busy;
      reset_dut();
      for (k = 0; k < 17; k++) begin
         if (k == 16 && desc_oflow !== 1'b0) begin
            report_value("desc_oflow", desc_oflow, 0);
         end
         push_desc(32'h5000_0000 + addr_t'(k * 'h100), 4);
      end
      if (desc_oflow !== 1'b1) begin
         report_value("desc_oflow", desc_oflow, 1);
      end
      for (k = 0; k < 16; k++) begin
         expect_packet(32'h5000_0000 + addr_t'(k * 'h100), 4, 60 + k, 2);
      end
      for (k = 0; k < 16; k++) begin
         send_packet(60 + k, 2);
      end
      wait_writes();
      check_ring_ptr();
      // The dropped descriptor must not pick up another packet
      send_packet(76, 2);
      busy = 0;
      for (k = 0; k < 40; k++) begin
         if (mem_wr_valid) begin
            busy++;
         end
         idle(1);
      end
      if (busy != 0) begin
         errors++;
         $display("A memory write was issued for a packet with no descriptor left");
      end
   endtask

   initial begin
      int k;
      int asserts;
      errors       = 0;
      lfsr_state   = 16'd11;
      rst_n        = 1'b0;
      desc_wr_req  = 1'b0;
      desc_wdata   = '0;
      axis_valid   = 1'b0;
      axis_data    = '0;
      axis_last    = 1'b0;
      mem_wr_ready = 1'b0;
      md_ring_addr = RING_BASE;
      exp_slot     = 0;
      // Lengths of 1 to 16 words
      for (k = 0; k < RAND_PKTS; k++) begin
         rand_len[k] = rand_bits(4) + 1;
      end

      test_reset_values();
      test_short_packet();
      test_truncated_packet();
      test_random_packets();
      test_buffer_full();
      test_desc_overflow();

      asserts = dut0.mem_arb0.arb_chk0.fail_count + dut0.desc_fifo0.fifo_chk0.fail_count;
      $display("Check errors: %0d, assertion failures: %0d", errors, asserts);
      if (errors == 0 && asserts == 0) begin
         $display("SIMULATION PASSED");
      end else begin
         $display("SIMULATION FAILED");
      end
      $finish;
   end

endmodule

/* src.f */
rtl/c2h_pkg.sv
rtl/c2h_desc_fifo.sv
rtl/c2h_pkt_buf.sv
rtl/c2h_data_mover.sv
rtl/c2h_write_back.sv
rtl/c2h_mem_arb.sv
rtl/c2h_top.sv
verification/c2h_tb_assert.sv
verification/c2h_tb.sv
